/* hdl/riscv_pkg.sv */
// Shared RV32I types for a 32-bit core without CSRs, traps or byte and halfword accesses
package riscv_pkg;

  // Data and address word
  typedef logic [31:0] word_t;

  // Major opcodes as found in instruction bits 6:0
  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_branch = 7'b1100011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_imm    = 7'b0010011,
    op_reg    = 7'b0110011,
    op_system = 7'b1110011
  } opcode_t;

  // Encoded exactly as funct3 of the integer ops
  typedef enum logic [2:0] {
    alu_add  = 3'b000,
    alu_sll  = 3'b001,
    alu_slt  = 3'b010,
    alu_sltu = 3'b011,
    alu_xor  = 3'b100,
    alu_shr  = 3'b101,
    alu_or   = 3'b110,
    alu_and  = 3'b111
  } alu_op_t;

  // Bit 1 picks the non-ALU sources
  typedef enum logic [1:0] {
    wb_alu       = 2'b00,
    wb_memory    = 2'b10,
    wb_pc_plus_4 = 2'b11
  } wr_reg_src_t;

  // First fetch address
  localparam word_t default_reset_pc = 32'h0000_0000;

endpackage

/* hdl/register_file.sv */
// Integer register file with x0 hardwired to zero and reads that are combinational
`timescale 1ns/1ps

module register_file (
  input  logic             clock,
  input  logic             reset,
  input  logic             write_enable,
  input  logic [4:0]       read_address1,
  input  logic [4:0]       read_address2,
  input  logic [4:0]       write_address,
  input  riscv_pkg::word_t write_data,
  output riscv_pkg::word_t read_data1,
  output riscv_pkg::word_t read_data2
);

  riscv_pkg::word_t registers [32];

  always_ff @(posedge clock) begin
    if (reset) begin
      registers <= '{default: '0};
    end else if (write_enable && (write_address != 5'd0)) begin
      registers[write_address] <= write_data;
    end
  end

  // Asynchronous read ports
  assign read_data1 = registers[read_address1];
  assign read_data2 = registers[read_address2];

  // A write aimed at x0 must leave it untouched
  assert property (@(posedge clock) disable iff (reset)
    (write_enable && (write_address == 5'd0)) |=> (registers[0] == '0))
    else $error("register_file: x0 = %h after write attempt", registers[0]);

endmodule

/* hdl/alu.sv */
// Combinational RV32I ALU whose flags always come from the adder (a - b when sub is high)
`timescale 1ns/1ps

module alu (
  input  riscv_pkg::word_t   a,
  input  riscv_pkg::word_t   b,
  input  riscv_pkg::alu_op_t alu_src,
  input  logic               sub,
  input  logic               arithmetic,
  output riscv_pkg::word_t   y,
  output logic               zero,
  output logic               negative,
  output logic               carry_out,
  output logic               overflow
);

  riscv_pkg::word_t b_operand;
  riscv_pkg::word_t sum;
  logic [4:0]       shamt;

  // Subtraction as a + ~b + 1
  assign b_operand = sub ? ~b : b;
  assign {carry_out, sum} = {1'b0, a} + {1'b0, b_operand} + {32'b0, sub};

  // Flags for the branch decision
  assign zero     = (sum == '0);
  assign negative = sum[31];
  assign overflow = (a[31] == b_operand[31]) && (sum[31] != a[31]);

  assign shamt = b[4:0];

  always_comb begin
    case (alu_src)
      riscv_pkg::alu_add:  y = sum;
      riscv_pkg::alu_sll:  y = a << shamt;
      riscv_pkg::alu_slt:  y = {31'b0, $signed(a) < $signed(b)};
      riscv_pkg::alu_sltu: y = {31'b0, a < b};
      riscv_pkg::alu_xor:  y = a ^ b;
      riscv_pkg::alu_shr: begin
        // sra when arithmetic, srl otherwise
        if (arithmetic) begin
          y = riscv_pkg::word_t'($signed(a) >>> shamt);
        end else begin
          y = a >> shamt;
        end
      end
      riscv_pkg::alu_or:   y = a | b;
      default:             y = a & b;
    endcase
  end

endmodule

/* hdl/immediate_extender.sv */
// Sign-extended immediate for the I, S, B, U and J formats; other opcodes give zero
`timescale 1ns/1ps

module immediate_extender (
  input  logic [31:0]      instruction,
  output riscv_pkg::word_t immediate
);

  logic sign;

  assign sign = instruction[31];

  always_comb begin
    case (instruction[6:0])
      // I format
      riscv_pkg::op_jalr, riscv_pkg::op_load, riscv_pkg::op_imm:
        immediate = {{20{sign}}, instruction[31:20]};
      // S format
      riscv_pkg::op_store:
        immediate = {{20{sign}}, instruction[31:25], instruction[11:7]};
      // B format, bit 0 always zero
      riscv_pkg::op_branch:
        immediate = {{19{sign}}, sign, instruction[7], instruction[30:25],
                     instruction[11:8], 1'b0};
      // U format
      riscv_pkg::op_lui, riscv_pkg::op_auipc:
        immediate = {instruction[31:12], 12'b0};
      // J format
      riscv_pkg::op_jal:
        immediate = {{11{sign}}, sign, instruction[19:12], instruction[20],
                     instruction[30:21], 1'b0};
      default:
        immediate = '0;
    endcase
  end

endmodule

/* hdl/dataflow.sv */
// RV32I datapath holding PC and IR; PC only moves when pc_en is high and starts at reset_pc
`timescale 1ns/1ps

module dataflow #(
  parameter riscv_pkg::word_t reset_pc = riscv_pkg::default_reset_pc
) (
  input  logic                     clock,
  input  logic                     reset,
  // Memory side
  input  riscv_pkg::word_t         mem_rdata,
  output riscv_pkg::word_t         mem_wdata,
  output riscv_pkg::word_t         mem_addr,
  // From the control unit
  input  logic                     alua_src,
  input  logic                     alub_src,
  input  riscv_pkg::alu_op_t       alu_src,
  input  logic                     sub,
  input  logic                     arithmetic,
  input  logic                     alupc_src,
  input  logic                     pc_src,
  input  logic                     pc_en,
  input  riscv_pkg::wr_reg_src_t   wr_reg_src,
  input  logic                     wr_reg_en,
  input  logic                     ir_en,
  input  logic                     mem_addr_src,
  // To the control unit
  output logic [6:0]               opcode,
  output logic [2:0]               funct3,
  output logic [6:0]               funct7,
  output logic                     zero,
  output logic                     negative,
  output logic                     carry_out,
  output logic                     overflow
);

  logic [31:0]      ir;
  logic [4:0]       rs1_addr;
  riscv_pkg::word_t pc;
  riscv_pkg::word_t new_pc;
  riscv_pkg::word_t rs1;
  riscv_pkg::word_t rs2;
  riscv_pkg::word_t rd_data;
  riscv_pkg::word_t immediate;
  riscv_pkg::word_t alu_a;
  riscv_pkg::word_t alu_b;
  riscv_pkg::word_t alu_y;
  riscv_pkg::word_t pc_plus_4;
  riscv_pkg::word_t jump_base;
  riscv_pkg::word_t jump_sum;
  riscv_pkg::word_t pc_target;

  // PC and instruction register
  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= reset_pc;
      ir <= '0;
    end else begin
      if (pc_en) pc <= new_pc;
      if (ir_en) ir <= mem_rdata;
    end
  end

  // LUI reads x0 so the ALU passes the immediate through
  assign rs1_addr = ir[19:15] & {5{~(ir[4] & ir[2])}};

  always_comb begin
    case (wr_reg_src)
      riscv_pkg::wb_memory:    rd_data = mem_rdata;
      riscv_pkg::wb_pc_plus_4: rd_data = pc_plus_4;
      default:                 rd_data = alu_y;
    endcase
  end

  register_file i_register_file (
    .clock        (clock),
    .reset        (reset),
    .write_enable (wr_reg_en),
    .read_address1(rs1_addr),
    .read_address2(ir[24:20]),
    .write_address(ir[11:7]),
    .write_data   (rd_data),
    .read_data1   (rs1),
    .read_data2   (rs2)
  );

  immediate_extender i_immediate_extender (
    .instruction(ir),
    .immediate  (immediate)
  );

  assign alu_a = alua_src ? pc : rs1;
  assign alu_b = alub_src ? immediate : rs2;

  alu i_alu (
    .a         (alu_a),
    .b         (alu_b),
    .alu_src   (alu_src),
    .sub       (sub),
    .arithmetic(arithmetic),
    .y         (alu_y),
    .zero      (zero),
    .negative  (negative),
    .carry_out (carry_out),
    .overflow  (overflow)
  );

  // Next PC: sequential or jump/branch target, JALR clears bit 0
  assign pc_plus_4 = pc + 32'd4;
  assign jump_base = alupc_src ? rs1 : pc;
  assign jump_sum  = jump_base + immediate;
  assign pc_target = {jump_sum[31:1], jump_sum[0] & ~alupc_src};
  assign new_pc    = pc_src ? pc_target : pc_plus_4;

  assign mem_addr  = mem_addr_src ? alu_y : pc;
  assign mem_wdata = rs2;

  // Instruction fields for decode
  assign opcode = ir[6:0];
  assign funct3 = ir[14:12];
  assign funct7 = ir[31:25];

  assert property (@(posedge clock) disable iff (reset) pc_en |=> (pc[1:0] == 2'b00))
    else $error("dataflow: misaligned pc = %h", pc);

endmodule

/* hdl/control_unit.sv */
// Multicycle RV32I FSM on a four-phase req/ack port; waits on ack without limit, halts on SYSTEM
`timescale 1ns/1ps

module control_unit (
  input  logic                   clock,
  input  logic                   reset,
  input  logic [6:0]             opcode,
  input  logic [2:0]             funct3,
  input  logic [6:0]             funct7,
  input  logic                   zero,
  input  logic                   negative,
  input  logic                   carry_out,
  input  logic                   overflow,
  input  logic                   mem_ack,
  output logic                   mem_req,
  output logic                   mem_we,
  output logic                   halted,
  output logic                   alua_src,
  output logic                   alub_src,
  output riscv_pkg::alu_op_t     alu_src,
  output logic                   sub,
  output logic                   arithmetic,
  output logic                   alupc_src,
  output logic                   pc_src,
  output logic                   pc_en,
  output riscv_pkg::wr_reg_src_t wr_reg_src,
  output logic                   wr_reg_en,
  output logic                   ir_en,
  output logic                   mem_addr_src
);

  typedef enum logic [3:0] {
    s_start, s_fetch, s_fetch_release, s_decode, s_execute,
    s_memory, s_memory_release, s_writeback, s_halted
  } state_t;

  state_t state;
  state_t next_state;
  logic   legal;
  logic   taken;
  logic   mem_access;
  logic   writes_result;

  always_ff @(posedge clock) begin
    if (reset) state <= s_start;
    else       state <= next_state;
  end

  // Supported subset, SYSTEM included in the illegal set
  always_comb begin
    case (opcode)
      riscv_pkg::op_lui, riscv_pkg::op_auipc, riscv_pkg::op_jal,
      riscv_pkg::op_imm:    legal = 1'b1;
      riscv_pkg::op_jalr:   legal = (funct3 == 3'b000);
      riscv_pkg::op_branch: legal = (funct3[2:1] != 2'b01);
      riscv_pkg::op_load,
      riscv_pkg::op_store:  legal = (funct3 == 3'b010);
      riscv_pkg::op_reg:    legal = (funct7 == 7'h00) ||
                                    ((funct7 == 7'h20) && (funct3 == 3'b000 || funct3 == 3'b101));
      default:              legal = 1'b0;
    endcase
  end

  // Branch outcome from the a - b flags
  always_comb begin
    case (funct3)
      3'b000:  taken = zero;
      3'b001:  taken = !zero;
      3'b100:  taken = negative ^ overflow;
      3'b101:  taken = !(negative ^ overflow);
      3'b110:  taken = !carry_out;
      default: taken = carry_out;
    endcase
  end

  assign mem_access    = (opcode == riscv_pkg::op_load) || (opcode == riscv_pkg::op_store);
  assign writes_result = !mem_access && (opcode != riscv_pkg::op_branch);

  // Datapath steering depends on the opcode only, so it holds from execute to writeback
  always_comb begin
    alua_src   = 1'b0;
    alub_src   = 1'b1;
    alu_src    = riscv_pkg::alu_add;
    sub        = 1'b0;
    arithmetic = 1'b0;
    alupc_src  = 1'b0;
    pc_src     = 1'b0;
    wr_reg_src = riscv_pkg::wb_alu;
    case (opcode)
      riscv_pkg::op_auipc: alua_src = 1'b1;
      riscv_pkg::op_jal: begin
        pc_src     = 1'b1;
        wr_reg_src = riscv_pkg::wb_pc_plus_4;
      end
      riscv_pkg::op_jalr: begin
        pc_src     = 1'b1;
        alupc_src  = 1'b1;
        wr_reg_src = riscv_pkg::wb_pc_plus_4;
      end
      riscv_pkg::op_branch: begin
        alub_src = 1'b0;
        sub      = 1'b1;
        pc_src   = taken;
      end
      riscv_pkg::op_load: wr_reg_src = riscv_pkg::wb_memory;
      riscv_pkg::op_imm: begin
        alu_src    = riscv_pkg::alu_op_t'(funct3);
        arithmetic = funct7[5];
      end
      riscv_pkg::op_reg: begin
        alub_src   = 1'b0;
        alu_src    = riscv_pkg::alu_op_t'(funct3);
        sub        = funct7[5] && (funct3 == 3'b000);
        arithmetic = funct7[5];
      end
      default: begin
      end
    endcase
  end

  // Sequencing and the memory handshake
  always_comb begin
    next_state   = state;
    mem_req      = 1'b0;
    mem_addr_src = 1'b0;
    ir_en        = 1'b0;
    pc_en        = 1'b0;
    wr_reg_en    = 1'b0;
    case (state)
      s_start:         if (!mem_ack) next_state = s_fetch;
      s_fetch: begin
        mem_req = 1'b1;
        if (mem_ack) begin
          ir_en      = 1'b1;
          next_state = s_fetch_release;
        end
      end
      s_fetch_release: if (!mem_ack) next_state = s_decode;
      s_decode:        next_state = legal ? s_execute : s_halted;
      s_execute:       next_state = mem_access ? s_memory : s_writeback;
      s_memory: begin
        mem_req      = 1'b1;
        mem_addr_src = 1'b1;
        if (mem_ack) begin
          // Load data is only valid while ack is high
          wr_reg_en  = (opcode == riscv_pkg::op_load);
          next_state = s_memory_release;
        end
      end
      s_memory_release: if (!mem_ack) next_state = s_writeback;
      s_writeback: begin
        pc_en      = 1'b1;
        wr_reg_en  = writes_result;
        next_state = s_fetch;
      end
      default:         next_state = s_halted;
    endcase
  end

  assign mem_we = (state == s_memory) && (opcode == riscv_pkg::op_store);
  assign halted = (state == s_halted) || ((state == s_decode) && !legal);

  assert property (@(posedge clock) disable iff (reset) $rose(mem_req) |-> !$past(mem_ack))
    else $error("control_unit: mem_req raised while mem_ack high");
  assert property (@(posedge clock) disable iff (reset)
    (mem_req && $past(mem_req)) |-> $stable(mem_we))
    else $error("control_unit: mem_we changed during request, now %h", mem_we);

endmodule

/* hdl/rv32i_core.sv */
// Multicycle RV32I core top with one four-phase memory port shared by fetch, LW and SW
`timescale 1ns/1ps

module rv32i_core #(
  parameter riscv_pkg::word_t reset_pc = riscv_pkg::default_reset_pc
) (
  input  logic             clock,
  input  logic             reset,
  output logic             mem_req,
  output logic             mem_we,
  output riscv_pkg::word_t mem_addr,
  output riscv_pkg::word_t mem_wdata,
  input  riscv_pkg::word_t mem_rdata,
  input  logic             mem_ack,
  output logic             halted
);

  // Control lines toward the datapath
  logic                   alua_src;
  logic                   alub_src;
  riscv_pkg::alu_op_t     alu_src;
  logic                   sub;
  logic                   arithmetic;
  logic                   alupc_src;
  logic                   pc_src;
  logic                   pc_en;
  riscv_pkg::wr_reg_src_t wr_reg_src;
  logic                   wr_reg_en;
  logic                   ir_en;
  logic                   mem_addr_src;
  // Decode fields and flags back
  logic [6:0]             opcode;
  logic [2:0]             funct3;
  logic [6:0]             funct7;
  logic                   zero;
  logic                   negative;
  logic                   carry_out;
  logic                   overflow;

  control_unit i_control_unit (
    .clock(clock), .reset(reset),
    .opcode(opcode), .funct3(funct3), .funct7(funct7),
    .zero(zero), .negative(negative), .carry_out(carry_out), .overflow(overflow),
    .mem_ack(mem_ack), .mem_req(mem_req), .mem_we(mem_we), .halted(halted),
    .alua_src(alua_src), .alub_src(alub_src), .alu_src(alu_src), .sub(sub),
    .arithmetic(arithmetic), .alupc_src(alupc_src), .pc_src(pc_src), .pc_en(pc_en),
    .wr_reg_src(wr_reg_src), .wr_reg_en(wr_reg_en), .ir_en(ir_en),
    .mem_addr_src(mem_addr_src)
  );

  dataflow #(
    .reset_pc(reset_pc)
  ) i_dataflow (
    .clock(clock), .reset(reset),
    .mem_rdata(mem_rdata), .mem_wdata(mem_wdata), .mem_addr(mem_addr),
    .alua_src(alua_src), .alub_src(alub_src), .alu_src(alu_src), .sub(sub),
    .arithmetic(arithmetic), .alupc_src(alupc_src), .pc_src(pc_src), .pc_en(pc_en),
    .wr_reg_src(wr_reg_src), .wr_reg_en(wr_reg_en), .ir_en(ir_en),
    .mem_addr_src(mem_addr_src),
    .opcode(opcode), .funct3(funct3), .funct7(funct7),
    .zero(zero), .negative(negative), .carry_out(carry_out), .overflow(overflow)
  );

endmodule

/* testbench/tb_memory.sv */
// Word-addressed memory on the four-phase port; ack and release delays are 0 to 5 cycles, no reset
`timescale 1ns/1ps

module tb_memory #(
  parameter int address_bits = 10
) (
  input  logic             clock,
  input  logic             req,
  input  logic             we,
  input  riscv_pkg::word_t addr,
  input  riscv_pkg::word_t wdata,
  output riscv_pkg::word_t rdata,
  output logic             ack
);

  // Program image and data, loaded by the testbench top
  riscv_pkg::word_t words [2**address_bits];

  // Responses change on the falling edge only
  initial begin
    int unsigned delay;
    int          guard;
    ack   = 1'b0;
    rdata = '0;
    forever begin
      @(negedge clock);
      if (req && !ack) begin
        delay = $urandom_range(5, 0);
        repeat (delay) @(negedge clock);
        if (we) begin
          words[addr[address_bits+1:2]] = wdata;
        end else begin
          rdata = words[addr[address_bits+1:2]];
        end
        ack = 1'b1;
        // Hold ack until req drops, bounded
        guard = 0;
        while (req && guard < 100) begin
          @(negedge clock);
          guard++;
        end
        delay = $urandom_range(5, 0);
        repeat (delay) @(negedge clock);
        ack = 1'b0;
      end
    end
  end

endmodule

/* testbench/tb_rv32i_core.sv */
// Code sits below 0x400 with operands at 0x400 and results from 0x500, all from one fixed seed
`timescale 1ns/1ps

module tb_rv32i_core;

  localparam riscv_pkg::word_t reset_pc = riscv_pkg::default_reset_pc;
  localparam int address_bits = 10;
  localparam int max_txn = 128;
  localparam int run_limit = 20000;
  localparam logic [31:0] nop = 32'h0000_0013;
  localparam logic [31:0] ebreak = 32'h0010_0073;

  logic             clock = 1'b0;
  logic             reset;
  logic             mem_req;
  logic             mem_we;
  logic             mem_ack;
  logic             halted;
  riscv_pkg::word_t mem_addr;
  riscv_pkg::word_t mem_wdata;
  riscv_pkg::word_t mem_rdata;

  // Expected port transactions in program order
  riscv_pkg::word_t exp_addr [max_txn];
  logic             exp_we   [max_txn];
  riscv_pkg::word_t exp_data [max_txn];
  int               txn_count = 0;
  int               txn_index;
  riscv_pkg::word_t build_pc;

  always #20 clock = ~clock;

  rv32i_core #(
    .reset_pc(reset_pc)
  ) i_rv32i_core (
    .clock(clock), .reset(reset),
    .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_rdata(mem_rdata), .mem_ack(mem_ack), .halted(halted)
  );

  tb_memory #(
    .address_bits(address_bits)
  ) i_tb_memory (
    .clock(clock), .req(mem_req), .we(mem_we), .addr(mem_addr),
    .wdata(mem_wdata), .rdata(mem_rdata), .ack(mem_ack)
  );

  // Count of completed transactions
  always @(posedge clock) begin
    if (reset) txn_index <= 0;
    else if (mem_req && mem_ack) txn_index <= txn_index + 1;
  end

  task automatic stop_on_failure(input string what);
    $display("%s", what);
    $display("Test failures found");
    $fatal(1, "simulation stopped");
  endtask

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, riscv_pkg::op_reg};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2);
    return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], riscv_pkg::op_store};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] offset, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
    return {offset[12], offset[10:5], rs2, rs1, f3, offset[4:1], offset[11],
            riscv_pkg::op_branch};
  endfunction

  function automatic logic [31:0] u_type(input riscv_pkg::word_t imm, input logic [4:0] rd,
                                          input logic [6:0] op);
    return {imm[31:12], rd, op};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] offset, input logic [4:0] rd);
    return {offset[20], offset[10:1], offset[11], offset[19:12], rd, riscv_pkg::op_jal};
  endfunction

  // RV32I branch conditions
  function automatic logic branch_taken(input logic [2:0] f3, input riscv_pkg::word_t v1,
                                        input riscv_pkg::word_t v2);
    case (f3)
      3'b000:  return v1 == v2;
      3'b001:  return v1 != v2;
      3'b100:  return $signed(v1) < $signed(v2);
      3'b101:  return $signed(v1) >= $signed(v2);
      3'b110:  return v1 < v2;
      default: return v1 >= v2;
    endcase
  endfunction

  task automatic expect_txn(input riscv_pkg::word_t addr, input logic we,
                            input riscv_pkg::word_t data);
    exp_addr[txn_count] = addr;
    exp_we[txn_count]   = we;
    exp_data[txn_count] = data;
    txn_count++;
  endtask

  // Fetched marks whether the core is expected to execute this word
  task automatic place(input logic [31:0] instr, input logic fetched);
    i_tb_memory.words[build_pc[address_bits+1:2]] = instr;
    if (fetched) expect_txn(build_pc, 1'b0, '0);
    build_pc = build_pc + 32'd4;
  endtask

  task automatic load_word(input logic [4:0] rd, input riscv_pkg::word_t addr);
    place(i_type(addr[11:0], 5'd0, 3'b010, rd, riscv_pkg::op_load), 1'b1);
    expect_txn(addr, 1'b0, '0);
  endtask

  task automatic store_result(input logic [4:0] rs2, input riscv_pkg::word_t addr,
                              input riscv_pkg::word_t value);
    place(s_type(addr[11:0], rs2), 1'b1);
    expect_txn(addr, 1'b1, value);
  endtask

  // Branch over one slot that only runs when the branch falls through
  task automatic run_branch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
                            input riscv_pkg::word_t v1, input riscv_pkg::word_t v2);
    logic taken;
    taken = branch_taken(f3, v1, v2);
    place(b_type(13'd8, rs2, rs1, f3), 1'b1);
    place(nop, !taken);
  endtask

  a_reset_idle: assert property (@(posedge clock) reset |=> (!mem_req && !halted))
    else stop_on_failure($sformatf("Mismatch mem_req/halted after reset: got %h/%h, expected 0/0",
                                   $sampled(mem_req), $sampled(halted)));
  a_in_trace: assert property (@(posedge clock) disable iff (reset)
    $rose(mem_req) |-> (txn_index < txn_count))
    else stop_on_failure("Memory request issued after the last expected transaction");
  a_addr: assert property (@(posedge clock) disable iff (reset)
    $rose(mem_req) |-> (mem_addr == exp_addr[txn_index]))
    else stop_on_failure($sformatf("Mismatch mem_addr: got %h, expected %h",
                                   $sampled(mem_addr), exp_addr[$sampled(txn_index)]));
  a_we: assert property (@(posedge clock) disable iff (reset)
    $rose(mem_req) |-> (mem_we == exp_we[txn_index]))
    else stop_on_failure($sformatf("Mismatch mem_we: got %h, expected %h",
                                   $sampled(mem_we), exp_we[$sampled(txn_index)]));
  a_wdata: assert property (@(posedge clock) disable iff (reset)
    (mem_req && mem_we) |-> (mem_wdata == exp_data[txn_index]))
    else stop_on_failure($sformatf("Mismatch mem_wdata: got %h, expected %h",
                                   $sampled(mem_wdata), exp_data[$sampled(txn_index)]));
  a_hold: assert property (@(posedge clock) disable iff (reset)
    (mem_req && !mem_ack) |=> (mem_req && $stable(mem_addr) && $stable(mem_we)
                               && $stable(mem_wdata)))
    else stop_on_failure("Request dropped or changed before mem_ack arrived");
  a_release: assert property (@(posedge clock) disable iff (reset)
    (mem_req && mem_ack) |=> !mem_req)
    else stop_on_failure("mem_req still high one cycle after mem_ack");
  a_no_overlap: assert property (@(posedge clock) disable iff (reset)
    $rose(mem_req) |-> !$past(mem_ack))
    else stop_on_failure("mem_req raised while mem_ack was still high");
  a_halt_point: assert property (@(posedge clock) disable iff (reset)
    $rose(halted) |-> (txn_index == txn_count))
    else stop_on_failure("halted rose before the program reached EBREAK");
  a_halt_quiet: assert property (@(posedge clock) disable iff (reset)
    halted |=> (halted && !mem_req))
    else stop_on_failure("Core left halt or requested memory after halting");

  initial begin
    riscv_pkg::word_t a;
    riscv_pkg::word_t b;
    riscv_pkg::word_t base;
    int               i;
    int               cycles;
    void'($urandom(32'h7e01));
    reset = 1'b1;
    // Negative a and positive b with a nonzero shift amount in b
    a = $urandom() | 32'h8000_0000;
    b = ($urandom() & 32'h7fff_ffff) | 32'h0000_0001;
    for (i = 0; i < 2**address_bits; i++) begin
      i_tb_memory.words[i] = 32'hbad0_0000 | riscv_pkg::word_t'(i << 2);
    end
    i_tb_memory.words[32'h400 >> 2] = a;
    i_tb_memory.words[32'h404 >> 2] = b;

    // Operand loads and each operation followed by a store of x3
    build_pc = reset_pc;
    load_word(5'd1, 32'h400);
    load_word(5'd2, 32'h404);
    place(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 1'b1);
    store_result(5'd3, 32'h500, a + b);
    place(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd3), 1'b1);
    store_result(5'd3, 32'h504, a - b);
    place(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd3), 1'b1);
    store_result(5'd3, 32'h508, a ^ b);
    place(r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd3), 1'b1);
    store_result(5'd3, 32'h50c, {31'b0, $signed(a) < $signed(b)});
    place(r_type(7'h00, 5'd2, 5'd1, 3'b011, 5'd3), 1'b1);
    store_result(5'd3, 32'h510, {31'b0, a < b});
    place(r_type(7'h20, 5'd2, 5'd1, 3'b101, 5'd3), 1'b1);
    store_result(5'd3, 32'h514, $signed(a) >>> b[4:0]);
    place(i_type(12'h007, 5'd1, 3'b001, 5'd3, riscv_pkg::op_imm), 1'b1);
    store_result(5'd3, 32'h518, a << 7);
    place(u_type(b, 5'd3, riscv_pkg::op_lui), 1'b1);
    store_result(5'd3, 32'h51c, {b[31:12], 12'b0});
    base = build_pc;
    place(u_type(a, 5'd3, riscv_pkg::op_auipc), 1'b1);
    store_result(5'd3, 32'h520, base + {a[31:12], 12'b0});

    // Each branch kind on (a, b), (b, a) and (a, a)
    for (i = 0; i < 8; i++) begin
      if (i != 2 && i != 3) begin
        run_branch(3'(i), 5'd1, 5'd2, a, b);
        run_branch(3'(i), 5'd2, 5'd1, b, a);
        run_branch(3'(i), 5'd1, 5'd1, a, a);
      end
    end

    // JAL skips two words and its link is stored
    base = build_pc;
    place(j_type(21'd12, 5'd5), 1'b1);
    place(nop, 1'b0);
    place(nop, 1'b0);
    store_result(5'd5, 32'h524, base + 32'd4);
    // JALR to base + 17 lands on base + 16 once bit 0 is cleared
    base = build_pc;
    place(u_type('0, 5'd6, riscv_pkg::op_auipc), 1'b1);
    place(i_type(12'd17, 5'd6, 3'b000, 5'd7, riscv_pkg::op_jalr), 1'b1);
    place(nop, 1'b0);
    place(nop, 1'b0);
    store_result(5'd7, 32'h528, base + 32'd8);
    place(ebreak, 1'b1);

    repeat (8) @(negedge clock);
    reset = 1'b0;

    cycles = 0;
    while (!halted && cycles < run_limit) begin
      @(negedge clock);
      cycles++;
    end
    if (!halted) begin
      stop_on_failure("Timed out waiting for halted");
    end else begin
      // Quiet window watched by the halt assertions
      repeat (50) @(negedge clock);
      if (txn_index == txn_count) begin
        $display("All tests passed!");
        $finish;
      end else begin
        stop_on_failure($sformatf("Only %0d of %0d expected memory transactions completed",
                                  txn_index, txn_count));
      end
    end
  end

endmodule

/* compile.f */
hdl/riscv_pkg.sv
hdl/register_file.sv
hdl/alu.sv
hdl/immediate_extender.sv
hdl/dataflow.sv
hdl/control_unit.sv
hdl/rv32i_core.sv
testbench/tb_memory.sv
testbench/tb_rv32i_core.sv

/* run.sh */
#!/bin/sh
# Build and run the rv32i_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --timescale 1ns/1ps \
  --top-module tb_rv32i_core -f compile.f -o tb_sim --Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
fi

if grep -q -F "All tests passed!" sim.log; then
  exit 0
else
  echo "Pass message not found in sim.log"
  exit 1
fi
